//--- source/dpram_pkg.sv
// Scratch memory widths, pipeline depth, opcode and state enums, request and response structs
package dpram_pkg;

    // Word and address sizes
    localparam int data_width = 16;
    localparam int addr_width = 6;
    localparam int mem_depth  = 1 << addr_width;

    // Cycles from op_valid to rd_valid through the core
    localparam int pipe_depth = 3;

    // Memory operation
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // One request as carried on a client port and into the core
    typedef struct packed {
        mem_op_e               op;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    // Read data, also returned for writes
    typedef struct packed {
        logic [data_width-1:0] rdata;
    } mem_rsp_t;

    // Four-phase adapter states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_issue = 2'd1,
        st_wait  = 2'd2,
        st_ack   = 2'd3
    } hs_state_e;

endpackage

//--- source/dpram_core.sv
// Three-stage pipelined true dual-port RAM with port A write priority and write-first reads
`timescale 1ns/1ps

module dpram_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                op_valid_a,
    input  logic                op_valid_b,
    input  dpram_pkg::mem_req_t op_a,
    input  dpram_pkg::mem_req_t op_b,
    output logic                rd_valid_a,
    output logic                rd_valid_b,
    output dpram_pkg::mem_rsp_t rd_a,
    output dpram_pkg::mem_rsp_t rd_b
);

    import dpram_pkg::*;

    // Storage array
    logic [data_width-1:0] mem [mem_depth];

    // Stage 1 operation registers
    logic     s1_valid_a;
    logic     s1_valid_b;
    mem_req_t s1_op_a;
    mem_req_t s1_op_b;

    // Write decode and forwarded read data in stage 1
    logic                  wr_a;
    logic                  wr_b;
    logic                  wr_b_eff;
    logic                  same_addr;
    logic [data_width-1:0] fwd_a;
    logic [data_width-1:0] fwd_b;

    // Stage 2 read registers
    logic     s2_valid_a;
    logic     s2_valid_b;
    mem_rsp_t s2_rd_a;
    mem_rsp_t s2_rd_b;

    // Stage 1 capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_a <= 1'b0;
            s1_valid_b <= 1'b0;
        end else begin
            s1_valid_a <= op_valid_a;
            s1_valid_b <= op_valid_b;
        end
    end

    always_ff @(posedge clk) begin
        s1_op_a <= op_a;
        s1_op_b <= op_b;
    end

    assign same_addr = (s1_op_a.addr == s1_op_b.addr);
    assign wr_a      = s1_valid_a && (s1_op_a.op == op_write);
    assign wr_b      = s1_valid_b && (s1_op_b.op == op_write);

    // Port B loses a same-address write collision
    assign wr_b_eff  = wr_b && !(wr_a && same_addr);

    // Write-first view of the array as seen by each port
    always_comb begin
        if (wr_a) begin
            fwd_a = s1_op_a.wdata;
        end else if (wr_b_eff && same_addr) begin
            fwd_a = s1_op_b.wdata;
        end else begin
            fwd_a = mem[s1_op_a.addr];
        end
    end

    always_comb begin
        if (wr_a && same_addr) begin
            fwd_b = s1_op_a.wdata;
        end else if (wr_b) begin
            fwd_b = s1_op_b.wdata;
        end else begin
            fwd_b = mem[s1_op_b.addr];
        end
    end

    // Array update at the end of stage 1
    always_ff @(posedge clk) begin
        if (wr_a) begin
            mem[s1_op_a.addr] <= s1_op_a.wdata;
        end
        if (wr_b_eff) begin
            mem[s1_op_b.addr] <= s1_op_b.wdata;
        end
    end

    // Stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid_a <= 1'b0;
            s2_valid_b <= 1'b0;
        end else begin
            s2_valid_a <= s1_valid_a;
            s2_valid_b <= s1_valid_b;
        end
    end

    always_ff @(posedge clk) begin
        s2_rd_a.rdata <= fwd_a;
        s2_rd_b.rdata <= fwd_b;
    end

    // Stage 3 output registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_a <= 1'b0;
            rd_valid_b <= 1'b0;
        end else begin
            rd_valid_a <= s2_valid_a;
            rd_valid_b <= s2_valid_b;
        end
    end

    always_ff @(posedge clk) begin
        rd_a <= s2_rd_a;
        rd_b <= s2_rd_b;
    end

    // Issue side must be clean once out of reset
    a_op_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(op_valid_a) && !$isunknown(op_valid_b)
    ) else $error("op_valid is X after reset");

    // Fixed latency per port in both directions
    a_latency_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        op_valid_a |-> ##pipe_depth rd_valid_a
    ) else $error("port A result missing after pipe_depth cycles");

    a_origin_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid_a |-> $past(op_valid_a, pipe_depth)
    ) else $error("port A result without an operation");

    a_latency_b: assert property (
        @(posedge clk) disable iff (!rst_n)
        op_valid_b |-> ##pipe_depth rd_valid_b
    ) else $error("port B result missing after pipe_depth cycles");

    a_origin_b: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid_b |-> $past(op_valid_b, pipe_depth)
    ) else $error("port B result without an operation");

endmodule

//--- source/port_handshake.sv
// Four-phase req/ack adapter issuing one RAM operation per client transaction
`timescale 1ns/1ps

module port_handshake (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  dpram_pkg::mem_req_t cmd,
    output logic                ack,
    output dpram_pkg::mem_rsp_t rsp,
    output logic                op_valid,
    output dpram_pkg::mem_req_t op,
    input  logic                rd_valid,
    input  dpram_pkg::mem_rsp_t rd
);

    import dpram_pkg::*;

    hs_state_e state;
    hs_state_e state_nxt;

    // Captured request and returned result
    mem_req_t cmd_q;
    mem_rsp_t rsp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req) begin
                    state_nxt = st_issue;
                end
            end
            // Single operation goes out here
            st_issue: begin
                state_nxt = st_wait;
            end
            st_wait: begin
                if (rd_valid) begin
                    state_nxt = st_ack;
                end
            end
            // Hold ack until the client lets go of req
            st_ack: begin
                if (!req) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // Client holds cmd stable while req is high
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait && rd_valid) begin
            rsp_q <= rd;
        end
    end

    assign op_valid = (state == st_issue);
    assign op       = cmd_q;
    assign ack      = (state == st_ack);
    assign rsp      = rsp_q;

    // Ack only answers a live request
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> req
    ) else $error("ack raised without req");

    // Core result only while this port waits for one
    a_rd_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid |-> state == st_wait
    ) else $error("rd_valid outside st_wait");

endmodule

//--- source/dpram_subsystem.sv
// Shared scratch memory top level with two req/ack client ports around the RAM core
`timescale 1ns/1ps

module dpram_subsystem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_a,
    input  dpram_pkg::mem_req_t cmd_a,
    output logic                ack_a,
    output dpram_pkg::mem_rsp_t rsp_a,
    input  logic                req_b,
    input  dpram_pkg::mem_req_t cmd_b,
    output logic                ack_b,
    output dpram_pkg::mem_rsp_t rsp_b
);

    import dpram_pkg::*;

    // Adapter to core, one set per port
    logic     op_valid_a;
    logic     op_valid_b;
    mem_req_t op_a;
    mem_req_t op_b;
    logic     rd_valid_a;
    logic     rd_valid_b;
    mem_rsp_t rd_a;
    mem_rsp_t rd_b;

    port_handshake u_port_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_a),
        .cmd      (cmd_a),
        .ack      (ack_a),
        .rsp      (rsp_a),
        .op_valid (op_valid_a),
        .op       (op_a),
        .rd_valid (rd_valid_a),
        .rd       (rd_a)
    );

    port_handshake u_port_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_b),
        .cmd      (cmd_b),
        .ack      (ack_b),
        .rsp      (rsp_b),
        .op_valid (op_valid_b),
        .op       (op_b),
        .rd_valid (rd_valid_b),
        .rd       (rd_b)
    );

    dpram_core u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid_a (op_valid_a),
        .op_valid_b (op_valid_b),
        .op_a       (op_a),
        .op_b       (op_b),
        .rd_valid_a (rd_valid_a),
        .rd_valid_b (rd_valid_b),
        .rd_a       (rd_a),
        .rd_b       (rd_b)
    );

endmodule

//--- testbench/tb_clock.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 50;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period;
            clk = ~clk;
        end
    end

    // Release lands just after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- testbench/tb_dpram.sv
// Trace-driven testbench for the dual-port scratch memory with req/ack exchanges on both ports
`timescale 1ns/1ps

module tb_dpram;

    import dpram_pkg::*;

    // Req to ack: one cycle to sample, one to issue, then the RAM pipeline
    localparam int ack_latency = pipe_depth + 2;
    localparam int wait_limit  = 50;

    logic        clk;
    logic        rst_n;
    logic        req_a;
    logic        req_b;
    mem_req_t    cmd_a;
    mem_req_t    cmd_b;
    logic        ack_a;
    logic        ack_b;
    mem_rsp_t    rsp_a;
    mem_rsp_t    rsp_b;
    logic [31:0] rng;
    int          n_done;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dpram_subsystem u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req_a (req_a),
        .cmd_a (cmd_a),
        .ack_a (ack_a),
        .rsp_a (rsp_a),
        .req_b (req_b),
        .cmd_b (cmd_b),
        .ack_b (ack_b),
        .rsp_b (rsp_b)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    function automatic logic port_ack(input int port);
        return (port == 0) ? ack_a : ack_b;
    endfunction

    function automatic logic [data_width-1:0] port_rdata(input int port);
        return (port == 0) ? rsp_a.rdata : rsp_b.rdata;
    endfunction

    task automatic drive_port(input int port, input logic level, input mem_req_t cmd);
        if (port == 0) begin
            cmd_a = cmd;
            req_a = level;
        end else begin
            cmd_b = cmd;
            req_b = level;
        end
    endtask

    // One four-phase exchange, entered and left 1 ns after a rising edge
    task automatic handshake(input int port, input mem_req_t cmd,
                             input logic [data_width-1:0] expected, input string name);
        int    cycles;
        string pname;
        pname = (port == 0) ? "A" : "B";
        drive_port(port, 1'b1, cmd);
        cycles = 0;
        while (!port_ack(port) && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!port_ack(port)) begin
            abort_run($sformatf("port %s hung with no ack after %0d cycles", pname, wait_limit));
        end
        compare_value({name, " rsp"}, 32'(expected), 32'(port_rdata(port)));
        compare_value({name, " ack latency"}, ack_latency, cycles);

        // Ack and rsp hold while req stays high
        @(posedge clk);
        #1;
        compare_value({name, " ack held"}, 32'd1, 32'(port_ack(port)));
        compare_value({name, " rsp held"}, 32'(expected), 32'(port_rdata(port)));
        drive_port(port, 1'b0, cmd);
        cycles = 0;
        while (port_ack(port) && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (port_ack(port)) begin
            abort_run($sformatf("port %s hung with ack stuck high after req fell", pname));
        end
        compare_value({name, " ack fall"}, 32'd1, cycles);
    endtask

    initial begin
        int          fd;
        int          count;
        int          line_no;
        int          gap;
        int          skew;
        string       line;
        logic [3:0]  mask;
        logic [3:0]  sync;
        logic [3:0]  a_op;
        logic [7:0]  a_addr;
        logic [15:0] a_wdata;
        logic [15:0] a_exp;
        logic [3:0]  b_op;
        logic [7:0]  b_addr;
        logic [15:0] b_wdata;
        logic [15:0] b_exp;
        mem_req_t    ca;
        mem_req_t    cb;

        req_a  = 1'b0;
        req_b  = 1'b0;
        cmd_a  = '0;
        cmd_b  = '0;
        rng    = 32'd6;
        n_done = 0;

        count = 0;
        while (rst_n !== 1'b1 && count < 40) begin
            @(posedge clk);
            count++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end

        // No request pending, so both acks stay low
        repeat (4) begin
            @(posedge clk);
            #1;
            compare_value("ack_a idle after reset", 32'd0, 32'(ack_a));
            compare_value("ack_b idle after reset", 32'd0, 32'(ack_b));
        end

        fd = $fopen("testbench/dpram_trace.txt", "r");
        if (fd == 0) begin
            abort_run("could not open testbench/dpram_trace.txt");
        end
        line_no = 0;
        while ($fgets(line, fd) > 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", mask, sync,
                            a_op, a_addr, a_wdata, a_exp, b_op, b_addr, b_wdata, b_exp);
            if (count != 10) begin
                abort_run($sformatf("trace line %0d is malformed", line_no));
            end
            ca.op    = mem_op_e'(a_op[0]);
            ca.addr  = a_addr[addr_width-1:0];
            ca.wdata = a_wdata;
            cb.op    = mem_op_e'(b_op[0]);
            cb.addr  = b_addr[addr_width-1:0];
            cb.wdata = b_wdata;

            rng  = xorshift32(rng);
            gap  = int'(rng[1:0]);
            skew = (mask == 4'd3 && !sync[0]) ? 1 + int'(rng[8]) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            fork
                if (mask[0]) begin
                    handshake(0, ca, a_exp, $sformatf("line %0d port A", line_no));
                end
                if (mask[1]) begin
                    repeat (skew) begin
                        @(posedge clk);
                        #1;
                    end
                    handshake(1, cb, b_exp, $sformatf("line %0d port B", line_no));
                end
            join
            n_done++;
        end
        $fclose(fd);

        if (n_done > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("trace file held no transactions");
        end
    end

endmodule

//--- testbench/dpram_trace.txt
# mask sync | port A: op addr wdata expected | port B: op addr wdata expected (all hex)
# mask 1=A 2=B 3=both, sync 1 raises both reqs in one cycle, op 0=read 1=write
1 0 1 05 1234 1234 0 00 0000 0000
1 0 0 05 0000 1234 0 00 0000 0000
2 0 0 00 0000 0000 1 0a beef beef
2 0 0 00 0000 0000 0 0a 0000 beef
1 0 1 10 cafe cafe 0 00 0000 0000
2 0 0 00 0000 0000 0 10 0000 cafe
2 0 0 00 0000 0000 1 11 f00d f00d
1 0 0 11 0000 f00d 0 00 0000 0000
3 1 1 20 aaaa aaaa 1 20 5555 aaaa
3 1 0 20 0000 aaaa 0 20 0000 aaaa
1 0 1 21 1111 1111 0 00 0000 0000
3 1 1 21 7777 7777 0 21 0000 7777
2 0 0 00 0000 0000 0 21 0000 7777
3 1 0 0a 0000 4321 1 0a 4321 4321
3 0 1 30 0102 0102 1 31 0304 0304
3 1 1 32 a5a5 a5a5 1 33 5a5a 5a5a
3 0 0 31 0000 0304 0 30 0000 0102
3 1 0 33 0000 5a5a 0 32 0000 a5a5
3 1 1 00 0f0f 0f0f 1 3f f0f0 f0f0
3 0 0 3f 0000 f0f0 0 00 0000 0f0f
3 1 1 3f 1357 1357 1 3f 2468 1357
2 0 0 00 0000 0000 0 3f 0000 1357
1 0 0 05 0000 1234 0 00 0000 0000

//--- src.f
source/dpram_pkg.sv
source/dpram_core.sv
source/port_handshake.sv
source/dpram_subsystem.sv
testbench/tb_clock.sv
testbench/tb_dpram.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run from the project root, pass only if the pass line shows up
verilator --binary --timing --assert --top-module tb_dpram -f src.f -o sim_dpram \
    && ./obj_dir/sim_dpram | awk '{ print } /^>>> PASS$/ { found = 1 } END { exit !found }' \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
